/* dv/phold_sched_chk.sv */
module phold_sched_chk (
   input logic               clk,
   input logic               rst_n,
   input phold_pkg::phase_e  phase,
   input logic               disp_vld,
   input logic               rtn_vld,
   input phold_pkg::time_t   gvt,
   input logic               pop,
   input logic               empty
);

   int fail_cnt = 0;   // failed assertions so far

   // dispatch strobe belongs to the running phase
   disp_in_running: assert property (@(posedge clk) disable iff (!rst_n)
      disp_vld |-> (phase == phold_pkg::RUNNING))
      else begin
         fail_cnt++;
         $error("dispatch strobe outside the RUNNING phase");
      end

   rtn_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      rtn_vld |=> !rtn_vld)
      else begin
         fail_cnt++;
         $error("completion strobe lasted more than one cycle");
      end

   // gvt only clears when a new run enters INIT
   gvt_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
      (phase != phold_pkg::INIT) |=> (gvt >= $past(gvt)))
      else begin
         fail_cnt++;
         $error("gvt decreased during a run");
      end

   pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> !empty)
      else begin
         fail_cnt++;
         $error("pop requested while the event queue is empty");
      end

endmodule

/* dv/tb_phold_sched.sv */
`include "phold_cfg.svh"

module tb_phold_sched;

   localparam int CBIT         = `PHOLD_TIME_WID + `PHOLD_NB_LPID;
   localparam int RESET_CYCLES = 10;
   localparam int RUN_CYCLES   = 3000;   // budget per run
   localparam int NUM_RUNS     = 2;

   logic              clk;
   logic              rst_n;
   logic              start;
   logic              in_vld;
   phold_pkg::msg_t   in_msg;
   logic              core_ready;
   logic              disp_vld;
   phold_pkg::msg_t   disp_msg;
   phold_pkg::time_t  gvt;
   logic              rtn_vld;
   phold_pkg::qcnt_t  q_cnt;

   phold_pkg::msg_t   ref_q[$];   // model queue with the head at index 0
   phold_pkg::time_t  exp_gvt;
   phold_pkg::time_t  last_time;
   logic [31:0]       lcg_state = 32'h48f48f1e;
   logic              gvt_pending = 1'b0;
   logic              run_over = 1'b0;
   int                errors = 0;
   int                assert_fails = 0;
   int                rtn_cnt = 0;
   int                disp_idx = 0;
   int                disp_total = 0;

   phold_sched u_phold_sched (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .in_vld     (in_vld),
      .in_msg     (in_msg),
      .core_ready (core_ready),
      .disp_vld   (disp_vld),
      .disp_msg   (disp_msg),
      .gvt        (gvt),
      .rtn_vld    (rtn_vld),
      .q_cnt      (q_cnt)
   );

   bind phold_sched phold_sched_chk u_phold_sched_chk (
      .clk      (clk),
      .rst_n    (rst_n),
      .phase    (phase),
      .disp_vld (disp_vld),
      .rtn_vld  (rtn_vld),
      .gvt      (gvt),
      .pop      (pop),
      .empty    (empty)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      return int'((next_random() >> 16) % n);   // upper bits are the better ones
   endfunction

   // time above the inverted cancel so an anti-message wins a tie
   function automatic phold_pkg::qkey_t sort_key(input phold_pkg::msg_t m);
      return {m[`PHOLD_TIME_WID-1:0], ~m[CBIT]};
   endfunction

   function automatic phold_pkg::msg_t seed_msg(input int lp);
      phold_pkg::msg_t m;
      m = '0;
      m[`PHOLD_TIME_WID +: `PHOLD_NB_LPID] = lp[`PHOLD_NB_LPID-1:0];
      return m;
   endfunction

   // expected gvt after a dispatch
   function automatic phold_pkg::time_t next_gvt(input phold_pkg::time_t prev,
                                                 input bit q_empty,
                                                 input phold_pkg::time_t head_t,
                                                 input phold_pkg::time_t last_t);
      phold_pkg::time_t cand;
      cand = q_empty ? last_t : head_t;
      return (cand > prev) ? cand : prev;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // goes behind every entry with an equal or smaller key
   task automatic ref_insert(input phold_pkg::msg_t m);
      int pos;
      pos = 0;
      while (pos < ref_q.size() && sort_key(ref_q[pos]) <= sort_key(m)) pos++;
      ref_q.insert(pos, m);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic start_run();
      run_over  = 1'b0;
      disp_idx  = 0;
      exp_gvt   = '0;
      last_time = '0;
      for (int i = 0; i < `PHOLD_NUM_SEED; i++) ref_insert(seed_msg(i));
      start = 1'b1;
      next_cycle();
      start = 1'b0;
   endtask

   // processing element stalls and answers each dispatch with one new event
   task automatic serve_core();
      phold_pkg::msg_t  ev;
      phold_pkg::time_t t;
      int               stall;
      while (!run_over) begin
         next_cycle();
         if (disp_vld) begin
            core_ready = 1'b0;
            t          = disp_msg[`PHOLD_TIME_WID-1:0];
            stall      = 1 + rand_below(4);
            repeat (stall) next_cycle();
            if (!run_over) begin
               if (rand_below(10) == 0) begin
                  ev       = '0;
                  ev[CBIT] = 1'b1;   // null message is never queued
                  in_vld   = 1'b1;
                  in_msg   = ev;
                  next_cycle();
               end
               ev = '0;
               ev[`PHOLD_TIME_WID-1:0] = t + phold_pkg::time_t'(1 + rand_below(16));
               ev[`PHOLD_TIME_WID +: `PHOLD_NB_LPID] = phold_pkg::lp_id_t'(rand_below(64));
               ev[CBIT] = (rand_below(8) == 0);
               in_vld   = 1'b1;
               in_msg   = ev;
               ref_insert(ev);
               next_cycle();
               in_vld   = 1'b0;
            end
            core_ready = 1'b1;   // new event already blocks the next pop
         end
      end
   endtask

   task automatic finish_run(input int run_no);
      int n;
      n = 0;
      while (rtn_cnt < run_no && n < 16) begin
         next_cycle();
         n++;
      end
      if (rtn_cnt < run_no) begin
         errors++;
         $display("run %0d: no completion strobe after gvt passed the end time", run_no);
      end
      repeat (20) next_cycle();   // any dispatch while idle is flagged
      check_value("rtn_count", run_no, rtn_cnt);
      check_value("q_cnt_idle", ref_q.size(), q_cnt);
   endtask

   // outputs sampled on the falling edge
   always @(negedge clk) begin
      phold_pkg::msg_t  exp_msg;
      phold_pkg::time_t head_t;
      if (gvt_pending) begin
         check_value("gvt", exp_gvt, gvt);
         gvt_pending = 1'b0;
      end
      if (rtn_vld) begin
         rtn_cnt++;
         if (!run_over) begin
            errors++;
            $display("completion strobe before gvt passed the end time");
         end
      end
      if (disp_vld) begin
         if (run_over) begin
            errors++;
            $display("dispatch seen after the run had completed");
         end else if (ref_q.size() == 0) begin
            errors++;
            $display("dispatch seen while the reference queue is empty");
         end else begin
            exp_msg = ref_q.pop_front();
            if (disp_idx < `PHOLD_NUM_SEED) begin
               check_value("seed_order", seed_msg(disp_idx), disp_msg);
            end
            check_value("dispatch", exp_msg, disp_msg);
            check_value("q_cnt", ref_q.size(), q_cnt);
            last_time = exp_msg[`PHOLD_TIME_WID-1:0];
            if (ref_q.size() > 0) head_t = ref_q[0][`PHOLD_TIME_WID-1:0];
            else head_t = '0;
            exp_gvt     = next_gvt(exp_gvt, ref_q.size() == 0, head_t, last_time);
            gvt_pending = 1'b1;   // register settles one cycle later
            disp_idx++;
            disp_total++;
            if (exp_gvt > `PHOLD_END_TIME) run_over = 1'b1;
         end
      end
   end

   initial begin
      repeat (RESET_CYCLES + NUM_RUNS * RUN_CYCLES) @(posedge clk);
      $display("watchdog expired, the runs did not complete in time");
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      start      = 1'b0;
      in_vld     = 1'b0;
      in_msg     = '0;
      core_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_value("reset_disp_vld", 0, disp_vld);
      check_value("reset_rtn_vld", 0, rtn_vld);
      check_value("reset_gvt", 0, gvt);
      check_value("reset_q_cnt", 0, q_cnt);
      next_cycle();
      for (int run = 1; run <= NUM_RUNS; run++) begin
         start_run();
         serve_core();
         finish_run(run);
      end
      assert_fails = u_phold_sched.u_phold_sched_chk.fail_cnt;
      $display("errors: %0d  assertion failures: %0d  dispatches: %0d  pulses: %0d",
               errors, assert_fails, disp_total, rtn_cnt);
      if (errors == 0 && assert_fails == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+verilog
verilog/phold_pkg.sv
verilog/sim_ctrl.sv
verilog/event_decode.sv
verilog/event_heap.sv
verilog/event_dispatch.sv
verilog/phold_sched.sv
dv/phold_sched_chk.sv
dv/tb_phold_sched.sv

/* verilog/event_decode.sv */
`include "phold_cfg.svh"

module event_decode (
   input  logic               clk,
   input  logic               rst_n,
   input  phold_pkg::phase_e  phase,
   input  logic               seed_vld,
   input  phold_pkg::lp_id_t  seed_lp,
   input  logic               in_vld,
   input  phold_pkg::msg_t    in_msg,
   input  logic               full,
   output logic               ins_vld,
   output phold_pkg::msg_t    ins_msg
);

   localparam int CBIT = `PHOLD_CANCEL_BIT;

   phold_pkg::msg_t cand_msg;
   logic            cand_vld;
   logic            is_null;

   // seeds during INIT, core events only while running
   always_comb begin
      cand_vld = 1'b0;
      cand_msg = '0;
      if (phase == phold_pkg::INIT) begin
         cand_vld = seed_vld;
         cand_msg[`PHOLD_TIME_WID +: `PHOLD_NB_LPID] = seed_lp;   // time zero, no cancel
      end else if (phase == phold_pkg::RUNNING) begin
         cand_vld = in_vld;
         cand_msg = in_msg;
      end
   end

   // null message is a cancel to lp 0 at time 0
   assign is_null = cand_msg[CBIT] && (cand_msg[CBIT-1:0] == '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) ins_vld <= 1'b0;
      else ins_vld <= cand_vld && !is_null && !full;
   end

   always_ff @(posedge clk) begin
      if (cand_vld) ins_msg <= cand_msg;
   end

endmodule

/* verilog/event_dispatch.sv */
`include "phold_cfg.svh"

module event_dispatch (
   input  logic               clk,
   input  logic               rst_n,
   input  phold_pkg::phase_e  phase,
   input  logic               ins_vld,
   input  logic               core_ready,
   input  logic               empty,
   input  phold_pkg::msg_t    head_msg,
   output logic               pop,
   output logic               disp_vld,
   output phold_pkg::msg_t    disp_msg,
   output phold_pkg::time_t   gvt
);

   phold_pkg::time_t head_time;
   phold_pkg::time_t last_time;   // time of last dispatched event
   phold_pkg::time_t cand_time;
   logic             running;

   assign running   = (phase == phold_pkg::RUNNING);
   assign head_time = head_msg[`PHOLD_TIME_WID-1:0];

   // insert has priority; stop dispatching once past the end time
   assign pop = running && !ins_vld && core_ready && !empty &&
                (gvt <= `PHOLD_END_TIME);

   assign cand_time = empty ? last_time : head_time;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         disp_vld  <= 1'b0;
         last_time <= '0;
         gvt       <= '0;
      end else begin
         disp_vld <= pop;
         if (phase == phold_pkg::INIT) begin
            last_time <= '0;   // new run starts at time zero
            gvt       <= '0;
         end else begin
            if (pop) last_time <= head_time;
            // monotonic, only advances while running
            if (running && (cand_time > gvt)) gvt <= cand_time;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop) disp_msg <= head_msg;
   end

endmodule

/* verilog/event_heap.sv */
`include "phold_cfg.svh"

module event_heap (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             ins_vld,
   input  phold_pkg::msg_t  ins_msg,
   input  logic             pop,
   output phold_pkg::msg_t  head_msg,
   output logic             empty,
   output logic             full,
   output phold_pkg::qcnt_t cnt
);

   localparam int DEPTH = `PHOLD_Q_DEPTH;
   localparam int CBIT  = `PHOLD_CANCEL_BIT;

   phold_pkg::msg_t  slot [DEPTH];   // slot 0 is the head
   logic [DEPTH-1:0] stay;
   phold_pkg::qkey_t new_key;
   logic             ins_ok;

   // cancel bit inverted so an anti-message sorts first at equal time
   function automatic phold_pkg::qkey_t key_of(input phold_pkg::msg_t m);
      return {m[`PHOLD_TIME_WID-1:0], ~m[CBIT]};
   endfunction

   assign new_key = key_of(ins_msg);
   assign ins_ok  = ins_vld && !full;

   // occupied slots with key <= new key keep their place,
   // so equal keys stay in arrival order
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         stay[i] = (i < cnt) && (key_of(slot[i]) <= new_key);
      end
   end

   always_ff @(posedge clk) begin
      if (ins_ok) begin
         if (!stay[0]) slot[0] <= ins_msg;
         for (int i = 1; i < DEPTH; i++) begin
            if (!stay[i]) begin
               if (stay[i-1]) slot[i] <= ins_msg;   // first slot past the keepers
               else slot[i] <= slot[i-1];           // shift up one
            end
         end
      end else if (pop) begin
         for (int i = 0; i < DEPTH-1; i++) begin
            slot[i] <= slot[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (ins_ok) begin
         cnt <= cnt + 1'b1;
      end else if (pop && !empty) begin
         cnt <= cnt - 1'b1;
      end
   end

   assign head_msg = slot[0];
   assign empty    = (cnt == '0);
   assign full     = (cnt == phold_pkg::qcnt_t'(DEPTH));

endmodule

/* verilog/phold_cfg.svh */
`ifndef PHOLD_CFG_SVH
`define PHOLD_CFG_SVH

// event message fields
`define PHOLD_TIME_WID 16
`define PHOLD_NB_LPID 6
`define PHOLD_MSG_WID 32

// cancel flag sits right above the lp id
`define PHOLD_CANCEL_BIT (`PHOLD_TIME_WID + `PHOLD_NB_LPID)

// event queue
`define PHOLD_Q_DEPTH 16
`define PHOLD_NB_QCNT 5

// run control
`define PHOLD_NUM_SEED 8
`define PHOLD_END_TIME 200

`endif

/* verilog/phold_pkg.sv */
`include "phold_cfg.svh"

package phold_pkg;

   // simulation timestamp
   typedef logic [`PHOLD_TIME_WID-1:0] time_t;

   typedef logic [`PHOLD_NB_LPID-1:0] lp_id_t;

   // {unused, cancel, lp id, time}
   typedef logic [`PHOLD_MSG_WID-1:0] msg_t;

   // {time, ~cancel}, smaller leaves first
   typedef logic [`PHOLD_TIME_WID:0] qkey_t;

   typedef logic [`PHOLD_NB_QCNT-1:0] qcnt_t;

   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      INIT     = 3'd1,
      READY    = 3'd2,
      RUNNING  = 3'd3,
      FINISHED = 3'd4
   } phase_e;

endpackage

/* verilog/phold_sched.sv */
`include "phold_cfg.svh"

module phold_sched (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  logic              in_vld,
   input  phold_pkg::msg_t   in_msg,
   input  logic              core_ready,
   output logic              disp_vld,
   output phold_pkg::msg_t   disp_msg,
   output phold_pkg::time_t  gvt,
   output logic              rtn_vld,
   output phold_pkg::qcnt_t  q_cnt
);

   phold_pkg::phase_e phase;
   phold_pkg::lp_id_t seed_lp;
   phold_pkg::msg_t   ins_msg;
   phold_pkg::msg_t   head_msg;
   logic              seed_vld;
   logic              ins_vld;
   logic              empty;
   logic              full;
   logic              pop;

   sim_ctrl u_sim_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .gvt      (gvt),
      .phase    (phase),
      .seed_vld (seed_vld),
      .seed_lp  (seed_lp),
      .rtn_vld  (rtn_vld)
   );

   event_decode u_event_decode (
      .clk      (clk),
      .rst_n    (rst_n),
      .phase    (phase),
      .seed_vld (seed_vld),
      .seed_lp  (seed_lp),
      .in_vld   (in_vld),
      .in_msg   (in_msg),
      .full     (full),
      .ins_vld  (ins_vld),
      .ins_msg  (ins_msg)
   );

   event_heap u_event_heap (
      .clk      (clk),
      .rst_n    (rst_n),
      .ins_vld  (ins_vld),
      .ins_msg  (ins_msg),
      .pop      (pop),
      .head_msg (head_msg),
      .empty    (empty),
      .full     (full),
      .cnt      (q_cnt)
   );

   event_dispatch u_event_dispatch (
      .clk        (clk),
      .rst_n      (rst_n),
      .phase      (phase),
      .ins_vld    (ins_vld),
      .core_ready (core_ready),
      .empty      (empty),
      .head_msg   (head_msg),
      .pop        (pop),
      .disp_vld   (disp_vld),
      .disp_msg   (disp_msg),
      .gvt        (gvt)
   );

endmodule

/* verilog/sim_ctrl.sv */
`include "phold_cfg.svh"

module sim_ctrl (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               start,
   input  phold_pkg::time_t   gvt,
   output phold_pkg::phase_e  phase,
   output logic               seed_vld,
   output phold_pkg::lp_id_t  seed_lp,
   output logic               rtn_vld
);

   phold_pkg::phase_e nxt_phase;
   phold_pkg::lp_id_t seed_cnt;
   logic              seeds_done;

   assign seeds_done = (seed_cnt == phold_pkg::lp_id_t'(`PHOLD_NUM_SEED));

   always_comb begin
      nxt_phase = phase;
      case (phase)
         phold_pkg::IDLE:     if (start) nxt_phase = phold_pkg::INIT;
         phold_pkg::INIT:     if (seeds_done) nxt_phase = phold_pkg::READY;
         phold_pkg::READY:    nxt_phase = phold_pkg::RUNNING;
         phold_pkg::RUNNING:  if (gvt > `PHOLD_END_TIME) nxt_phase = phold_pkg::FINISHED;
         phold_pkg::FINISHED: nxt_phase = phold_pkg::IDLE;   // wait for next start
         default:             nxt_phase = phold_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase    <= phold_pkg::IDLE;
         rtn_vld  <= 1'b0;
         seed_vld <= 1'b0;
         seed_lp  <= '0;
         seed_cnt <= '0;
      end else begin
         phase   <= nxt_phase;
         // high only during the FINISHED cycle
         rtn_vld <= (phase == phold_pkg::RUNNING) && (nxt_phase == phold_pkg::FINISHED);

         // one seed per INIT cycle, lp 0 upwards
         seed_vld <= (phase == phold_pkg::INIT) && !seeds_done;
         if ((phase == phold_pkg::INIT) && !seeds_done) begin
            seed_lp  <= seed_cnt;
            seed_cnt <= seed_cnt + 1'b1;
         end else if (phase != phold_pkg::INIT) begin
            seed_cnt <= '0;   // ready for next run
         end
      end
   end

endmodule
